/* common/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////
    // Core sizes
    ////////////////////////////////////////

    localparam int ARCH_REGS  = 8;
    localparam int PHYS_REGS  = 16;
    localparam int ROB_DEPTH  = 4;
    localparam int DATA_W     = 16;
    // Tags beyond the architectural set start out free
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    // Execution latency in cycles
    localparam int MUL_CYCLES = 4;
    localparam int ALU_CYCLES = 1;

    ////////////////////////////////////////
    // Index and data types
    ////////////////////////////////////////

    typedef logic [$clog2(ARCH_REGS)-1:0]    arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]    phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]    rob_idx_t;
    typedef logic [$clog2(ROB_DEPTH+1)-1:0]  rob_cnt_t;
    typedef logic [$clog2(FREE_DEPTH)-1:0]   free_idx_t;
    typedef logic [$clog2(FREE_DEPTH+1)-1:0] free_cnt_t;
    typedef logic [$clog2(MUL_CYCLES+1)-1:0] lat_cnt_t;
    typedef logic [DATA_W-1:0]               data_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        // Load immediate, ignores both sources
        OP_LDI = 3'd4
    } op_e;

    // One reorder buffer slot
    typedef struct packed {
        op_e       op;
        arch_idx_t dest_arch;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        data_t     imm;
        logic      done;
    } rob_entry_t;

endpackage

`default_nettype wire

/* common/issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Oldest unissued ROB entry offered to the issue controller
interface issue_if;
    import rename_pkg::*;

    logic      valid;
    op_e       op;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dest_tag;
    data_t     imm;
    // One-cycle strobe, entry written back
    logic      complete;

    modport rob (
        output valid, op, src1_tag, src2_tag, dest_tag, imm,
        input  complete
    );

    modport ctrl (
        input  valid, op, src1_tag, src2_tag, dest_tag, imm,
        output complete
    );

endinterface

`default_nettype wire

/* rename/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 alloc,
    input  wire rename_pkg::arch_idx_t rd,
    input  wire rename_pkg::arch_idx_t rs1,
    input  wire rename_pkg::arch_idx_t rs2,
    input  wire rename_pkg::phys_tag_t new_tag,
    output rename_pkg::phys_tag_t      src1_tag,
    output rename_pkg::phys_tag_t      src2_tag,
    output rename_pkg::phys_tag_t      old_tag,
    output logic                       take_tag
);
    import rename_pkg::*;

    // Speculative map, arch reg to physical tag
    phys_tag_t map_q [ARCH_REGS];

    // Sources see the mapping from before this instruction
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    // Previous owner of rd, freed when this one retires
    assign old_tag  = map_q[rd];

    // r0 keeps tag 0 and takes nothing from the free list
    assign take_tag = alloc && (rd != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Identity mapping, rN on tag N
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (take_tag) begin
            map_q[rd] <= new_tag;
        end
    end

endmodule

`default_nettype wire

/* rename/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  pop,
    input  wire logic                  push,
    input  wire rename_pkg::phys_tag_t push_tag,
    output rename_pkg::phys_tag_t      head_tag
);
    import rename_pkg::*;

    phys_tag_t slots [FREE_DEPTH];
    free_idx_t rd_ptr;
    free_idx_t wr_ptr;
    free_cnt_t count;

    // Next tag handed to a renamed destination
    assign head_tag = slots[rd_ptr];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Full at reset with the spare tags in order
            for (int i = 0; i < FREE_DEPTH; i++) begin
                slots[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= free_cnt_t'(FREE_DEPTH);
        end else begin
            // Retired old tag goes to the back
            if (push) begin
                slots[wr_ptr] <= push_tag;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave count unchanged
            count <= count + free_cnt_t'(push) - free_cnt_t'(pop);
        end
    end

    // ROB depth bounds in-flight renames below the spare count
    assert property (@(posedge clock) disable iff (!rst_n) pop |-> count != '0)
        else $error("free_list: pop while empty");

    // Only tags taken earlier come back
    assert property (@(posedge clock) disable iff (!rst_n)
        push |-> count != free_cnt_t'(FREE_DEPTH))
        else $error("free_list: push while full");

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  alloc,
    input  wire rename_pkg::op_e       op,
    input  wire rename_pkg::arch_idx_t rd,
    input  wire rename_pkg::data_t     imm,
    input  wire rename_pkg::phys_tag_t new_tag,
    input  wire rename_pkg::phys_tag_t old_tag,
    input  wire rename_pkg::phys_tag_t src1_tag,
    input  wire rename_pkg::phys_tag_t src2_tag,
    issue_if.rob                       iss,
    output logic                       dispatch_ready,
    output logic                       retire,
    output rename_pkg::arch_idx_t      retire_rd,
    output rename_pkg::phys_tag_t      retire_tag,
    output logic                       free_push,
    output rename_pkg::phys_tag_t      free_tag
);
    import rename_pkg::*;

    rob_entry_t rob_q [ROB_DEPTH];

    // Oldest entry, oldest unissued entry, next free slot
    rob_idx_t head;
    rob_idx_t iss_ptr;
    rob_idx_t tail;
    // Occupied entries and entries still waiting to issue
    rob_cnt_t count;
    rob_cnt_t n_pend;

    rob_entry_t head_entry;
    rob_entry_t iss_entry;

    assign head_entry = rob_q[head];
    assign iss_entry  = rob_q[iss_ptr];

    ////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////

    // Sole back-pressure point
    assign dispatch_ready = (count != rob_cnt_t'(ROB_DEPTH));

    ////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////

    assign iss.valid    = (n_pend != '0);
    assign iss.op       = iss_entry.op;
    assign iss.src1_tag = iss_entry.src1_tag;
    assign iss.src2_tag = iss_entry.src2_tag;
    assign iss.dest_tag = iss_entry.dest_tag;
    assign iss.imm      = iss_entry.imm;

    ////////////////////////////////////////
    // Retire side
    ////////////////////////////////////////

    // Head retires one cycle after its done bit lands
    assign retire     = (count != '0) && head_entry.done;
    assign retire_rd  = head_entry.dest_arch;
    assign retire_tag = head_entry.dest_tag;
    // Tag 0 belongs to r0 for good
    assign free_push  = retire && (head_entry.old_tag != '0);
    assign free_tag   = head_entry.old_tag;

    // Entry storage
    always_ff @(posedge clock) begin
        if (alloc) begin
            rob_q[tail].op        <= op;
            rob_q[tail].dest_arch <= rd;
            // Writes to r0 land on tag 0 and are dropped at the PRF
            rob_q[tail].dest_tag  <= (rd != '0) ? new_tag : '0;
            rob_q[tail].old_tag   <= old_tag;
            rob_q[tail].src1_tag  <= src1_tag;
            rob_q[tail].src2_tag  <= src2_tag;
            rob_q[tail].imm       <= imm;
            rob_q[tail].done      <= 1'b0;
        end
        if (iss.complete) begin
            rob_q[iss_ptr].done <= 1'b1;
        end
    end

    // Pointers and counts
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head    <= '0;
            iss_ptr <= '0;
            tail    <= '0;
            count   <= '0;
            n_pend  <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            if (iss.complete) begin
                iss_ptr <= iss_ptr + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count  <= count + rob_cnt_t'(alloc) - rob_cnt_t'(retire);
            n_pend <= n_pend + rob_cnt_t'(alloc) - rob_cnt_t'(iss.complete);
        end
    end

    // A strobe while dispatch_ready was low would overwrite the head
    assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> count != rob_cnt_t'(ROB_DEPTH))
        else $error("reorder_buffer: dispatch while full");

endmodule

`default_nettype wire

/* src/exec_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_timer (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire logic            start,
    input  wire rename_pkg::op_e op,
    output logic                 expired
);
    import rename_pkg::*;

    // Cycles left in the current operation
    lat_cnt_t cnt;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start) begin
            // Multiply is the only long op
            cnt <= (op == OP_MUL) ? lat_cnt_t'(MUL_CYCLES) : lat_cnt_t'(ALU_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Last count, the next edge brings it to zero
    assign expired = (cnt == lat_cnt_t'(1));

endmodule

`default_nettype wire

/* src/issue_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_fsm (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire rename_pkg::data_t  src1_data,
    input  wire rename_pkg::data_t  src2_data,
    input  wire logic               expired,
    issue_if.ctrl                   iss,
    output rename_pkg::phys_tag_t   src1_rd_tag,
    output rename_pkg::phys_tag_t   src2_rd_tag,
    output logic                    timer_start,
    output logic                    wr_en,
    output rename_pkg::phys_tag_t   wr_tag,
    output rename_pkg::data_t       wr_data
);
    import rename_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        WRITE
    } state_e;

    state_e                  state;
    data_t                   result_q;
    logic [2*DATA_W-1:0]     product;

    // PRF read tags follow the entry on offer
    assign src1_rd_tag = iss.src1_tag;
    assign src2_rd_tag = iss.src2_tag;

    // Full width, low half kept
    assign product = src1_data * src2_data;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:  if (iss.valid) state <= READ;
                READ:  state <= WAIT;
                WAIT:  if (expired) state <= WRITE;
                // Back to IDLE while the ROB steps its issue pointer
                WRITE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands are read and the result formed in READ
    always_ff @(posedge clock) begin
        if (state == READ) begin
            case (iss.op)
                OP_ADD:  result_q <= src1_data + src2_data;
                OP_SUB:  result_q <= src1_data - src2_data;
                OP_XOR:  result_q <= src1_data ^ src2_data;
                OP_MUL:  result_q <= product[DATA_W-1:0];
                OP_LDI:  result_q <= iss.imm;
                default: result_q <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // Latency starts counting as the operands are taken
    assign timer_start  = (state == READ);
    assign iss.complete = (state == WRITE);

    // r0 destinations complete without a register write
    assign wr_en   = (state == WRITE) && (iss.dest_tag != '0);
    assign wr_tag  = iss.dest_tag;
    assign wr_data = result_q;

    // Entry must stay on offer from IDLE through WRITE
    assert property (@(posedge clock) disable iff (!rst_n) iss.complete |-> iss.valid)
        else $error("issue_fsm: complete without a valid entry");

endmodule

`default_nettype wire

/* src/phys_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire rename_pkg::phys_tag_t rd1_tag,
    input  wire rename_pkg::phys_tag_t rd2_tag,
    input  wire rename_pkg::phys_tag_t rd3_tag,
    input  wire logic                  wr_en,
    input  wire rename_pkg::phys_tag_t wr_tag,
    input  wire rename_pkg::data_t     wr_data,
    output rename_pkg::data_t          rd1_data,
    output rename_pkg::data_t          rd2_data,
    output rename_pkg::data_t          rd3_data
);
    import rename_pkg::*;

    data_t regs [PHYS_REGS];

    // Tag 0 is hard zero
    assign rd1_data = (rd1_tag == '0) ? '0 : regs[rd1_tag];
    assign rd2_data = (rd2_tag == '0) ? '0 : regs[rd2_tag];
    // Retire port
    assign rd3_data = (rd3_tag == '0) ? '0 : regs[rd3_tag];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_tag] <= wr_data;
        end
    end

    // Issue side filters r0 destinations
    assert property (@(posedge clock) disable iff (!rst_n) wr_en |-> wr_tag != '0)
        else $error("phys_regfile: write to tag 0");

endmodule

`default_nettype wire

/* src/rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  instr_valid,
    input  wire rename_pkg::op_e       op,
    input  wire rename_pkg::arch_idx_t rd,
    input  wire rename_pkg::arch_idx_t rs1,
    input  wire rename_pkg::arch_idx_t rs2,
    input  wire rename_pkg::data_t     imm,
    output logic                       dispatch_ready,
    output logic                       commit_valid,
    output rename_pkg::arch_idx_t      commit_rd,
    output rename_pkg::data_t          commit_data
);
    import rename_pkg::*;

    ////////////////////////////////////////
    // Wires
    ////////////////////////////////////////

    // Rename
    logic      alloc;
    logic      take_tag;
    phys_tag_t new_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t old_tag;

    // Retire
    phys_tag_t retire_tag;
    logic      free_push;
    phys_tag_t free_tag;

    // Execute
    phys_tag_t src1_rd_tag;
    phys_tag_t src2_rd_tag;
    data_t     src1_data;
    data_t     src2_data;
    logic      timer_start;
    logic      expired;
    logic      wr_en;
    phys_tag_t wr_tag;
    data_t     wr_data;

    issue_if issue_bus ();

    // Strobe only counts while the ROB has room
    assign alloc = instr_valid && dispatch_ready;

    ////////////////////////////////////////
    // Rename and allocate
    ////////////////////////////////////////

    rename_table u_rename_table (
        .clock    (clock),
        .rst_n    (rst_n),
        .alloc    (alloc),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .new_tag  (new_tag),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .old_tag  (old_tag),
        .take_tag (take_tag)
    );

    free_list u_free_list (
        .clock    (clock),
        .rst_n    (rst_n),
        .pop      (take_tag),
        .push     (free_push),
        .push_tag (free_tag),
        .head_tag (new_tag)
    );

    reorder_buffer u_rob (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc          (alloc),
        .op             (op),
        .rd             (rd),
        .imm            (imm),
        .new_tag        (new_tag),
        .old_tag        (old_tag),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .iss            (issue_bus.rob),
        .dispatch_ready (dispatch_ready),
        .retire         (commit_valid),
        .retire_rd      (commit_rd),
        .retire_tag     (retire_tag),
        .free_push      (free_push),
        .free_tag       (free_tag)
    );

    ////////////////////////////////////////
    // Issue and execute
    ////////////////////////////////////////

    issue_fsm u_issue_fsm (
        .clock       (clock),
        .rst_n       (rst_n),
        .src1_data   (src1_data),
        .src2_data   (src2_data),
        .expired     (expired),
        .iss         (issue_bus.ctrl),
        .src1_rd_tag (src1_rd_tag),
        .src2_rd_tag (src2_rd_tag),
        .timer_start (timer_start),
        .wr_en       (wr_en),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data)
    );

    // Latency picked from the op on offer
    exec_timer u_exec_timer (
        .clock   (clock),
        .rst_n   (rst_n),
        .start   (timer_start),
        .op      (issue_bus.op),
        .expired (expired)
    );

    // Port 3 returns the retiring value
    phys_regfile u_prf (
        .clock    (clock),
        .rst_n    (rst_n),
        .rd1_tag  (src1_rd_tag),
        .rd2_tag  (src2_rd_tag),
        .rd3_tag  (retire_tag),
        .wr_en    (wr_en),
        .wr_tag   (wr_tag),
        .wr_data  (wr_data),
        .rd1_data (src1_data),
        .rd2_data (src2_data),
        .rd3_data (commit_data)
    );

endmodule

`default_nettype wire

/* test/tb_rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;
    import rename_pkg::*;

    ////////////////////////////////////////
    // Run length and limits
    ////////////////////////////////////////

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_INSTR    = 400;
    // Worst case per instruction is a multiply behind a full ROB
    localparam int WATCHDOG_CYCLES = NUM_INSTR * (MUL_CYCLES + 4) * ROB_DEPTH + 500;

    // DUT ports
    logic      clock;
    logic      rst_n;
    logic      instr_valid;
    op_e       op;
    arch_idx_t rd;
    arch_idx_t rs1;
    arch_idx_t rs2;
    data_t     imm;
    logic      dispatch_ready;
    logic      commit_valid;
    arch_idx_t commit_rd;
    data_t     commit_data;

    // Reference model, architectural state and expected commits
    data_t     arch_regs [ARCH_REGS];
    arch_idx_t exp_rd_q [$];
    data_t     exp_data_q [$];

    logic [31:0] rng;
    int          sent;
    int          committed;
    // Model of ROB occupancy
    int          in_flight;
    int          burst_left;
    logic        saw_backpressure;
    logic        accept;
    logic        drive_next;

    // Next instruction, applied at the rising edge
    op_e       next_op;
    arch_idx_t next_rd;
    arch_idx_t next_rs1;
    arch_idx_t next_rs2;
    data_t     next_imm;

    rename_core DUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .op             (op),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .dispatch_ready (dispatch_ready),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s: expected %0b, actual %0b", name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input arch_idx_t expected,
                             input arch_idx_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s: expected r%0d, actual r%0d", name, expected, actual));
        end
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s: expected %04h, actual %04h", name, expected, actual));
        end
    endtask

    // Shifts 13, 17, 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Wraps at 16 bits like the datapath
    function automatic data_t model_result(input op_e o, input data_t a, input data_t b,
                                           input data_t i);
        data_t r;
        case (o)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_XOR:  r = a ^ b;
            OP_MUL:  r = data_t'(a * b);
            OP_LDI:  r = i;
            default: r = '0;
        endcase
        return r;
    endfunction

    // Mostly ALU ops and loads, now and then a run of multiplies
    task automatic draw_instruction();
        logic [31:0] r;
        rng = xorshift32(rng);
        r   = rng;
        if (burst_left > 0) begin
            next_op = OP_MUL;
            burst_left--;
        end else if (r[7:4] == 4'd0) begin
            // Burst of 4 to 7
            next_op    = OP_MUL;
            burst_left = 3 + int'(r[9:8]);
        end else begin
            case (r[2:0])
                3'd0, 3'd1: next_op = OP_ADD;
                3'd2:       next_op = OP_SUB;
                3'd3:       next_op = OP_XOR;
                3'd4:       next_op = OP_MUL;
                default:    next_op = OP_LDI;
            endcase
        end
        next_rd  = r[12:10];
        next_rs1 = r[15:13];
        next_rs2 = r[18:16];
        rng      = xorshift32(rng);
        next_imm = rng[15:0];
    endtask

    // Executes at dispatch, r0 stays zero
    task automatic model_dispatch();
        data_t result;
        result = model_result(op, arch_regs[rs1], arch_regs[rs2], imm);
        if (rd != '0) begin
            arch_regs[rd] = result;
        end else begin
            result = '0;
        end
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
    endtask

    // Commits must come back in dispatch order
    task automatic check_commit();
        arch_idx_t exp_rd;
        data_t     exp_data;
        if (exp_rd_q.size() == 0) begin
            fail_run("commit_valid rose with no instruction outstanding");
        end else begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_reg($sformatf("commit %0d rd", committed), exp_rd, commit_rd);
            check_data($sformatf("commit %0d data", committed), exp_data, commit_data);
            committed++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////

    initial begin : stimulus
        for (int i = 0; i < ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end
        rng              = 32'he7f1;
        sent             = 0;
        committed        = 0;
        in_flight        = 0;
        burst_left       = 0;
        saw_backpressure = 1'b0;
        rst_n            = 1'b0;
        instr_valid      = 1'b0;
        op               = OP_ADD;
        rd               = '0;
        rs1              = '0;
        rs2              = '0;
        imm              = '0;

        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_flag("reset commit_valid", 1'b0, commit_valid);
        check_flag("reset dispatch_ready", 1'b1, dispatch_ready);

        while (committed < NUM_INSTR) begin
            // Falling edge, outputs settled for the coming rising edge
            check_flag("dispatch_ready", in_flight != ROB_DEPTH, dispatch_ready);
            if (!dispatch_ready) begin
                saw_backpressure = 1'b1;
            end
            accept = instr_valid && dispatch_ready;
            if (commit_valid) begin
                check_commit();
            end
            if (accept) begin
                model_dispatch();
                sent++;
            end
            in_flight = in_flight + int'(accept) - int'(commit_valid);

            // Drive only if the ROB still has room after this edge
            rng        = xorshift32(rng);
            drive_next = (sent < NUM_INSTR) && (in_flight != ROB_DEPTH) && (rng[2:0] != 3'd0);
            if (drive_next) begin
                draw_instruction();
            end

            @(posedge clock);
            instr_valid <= drive_next;
            if (drive_next) begin
                op  <= next_op;
                rd  <= next_rd;
                rs1 <= next_rs1;
                rs2 <= next_rs2;
                imm <= next_imm;
            end
            @(negedge clock);
        end

        if (!saw_backpressure) begin
            fail_run("dispatch_ready never dropped during the run");
        end
        // Nothing further may retire
        repeat (3 * MUL_CYCLES) begin
            @(negedge clock);
            check_flag("idle commit_valid", 1'b0, commit_valid);
        end

        $display("** PASS **");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        fail_run("timeout, not all instructions committed in time");
    end

endmodule

`default_nettype wire

/* flist.f */
common/rename_pkg.sv
common/issue_if.sv
rename/rename_table.sv
rename/free_list.sv
rob/reorder_buffer.sv
src/exec_timer.sv
src/issue_fsm.sv
src/phys_regfile.sv
src/rename_core.sv
test/tb_rename_core.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_core -f flist.f -o tb_rename_core \
    && { ./obj_dir/tb_rename_core > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx '\*\* PASS \*\*' sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
